// ==== noc_pkg.sv ====
package noc_pkg;

    localparam int FLIT_WIDTH = 32;

    localparam int CHANNEL_NUMBER = 5;
    localparam int CHANNEL_WIDTH = $clog2(CHANNEL_NUMBER);

    localparam int MAX_ROUTERS_X = 4;
    localparam int MAX_ROUTERS_Y = 4;
    localparam int COORD_X_WIDTH = $clog2(MAX_ROUTERS_X);
    localparam int COORD_Y_WIDTH = $clog2(MAX_ROUTERS_Y);

    localparam int HDR_PAYLOAD_WIDTH = FLIT_WIDTH - COORD_X_WIDTH - COORD_Y_WIDTH;

    // Output channel numbering
    localparam logic [CHANNEL_WIDTH-1:0] CH_LOCAL = CHANNEL_WIDTH'(0);
    localparam logic [CHANNEL_WIDTH-1:0] CH_NORTH = CHANNEL_WIDTH'(1); // y smaller
    localparam logic [CHANNEL_WIDTH-1:0] CH_EAST  = CHANNEL_WIDTH'(2); // x larger
    localparam logic [CHANNEL_WIDTH-1:0] CH_SOUTH = CHANNEL_WIDTH'(3); // y larger
    localparam logic [CHANNEL_WIDTH-1:0] CH_WEST  = CHANNEL_WIDTH'(4); // x smaller

    typedef struct packed {
        logic [COORD_X_WIDTH-1:0]     target_x;
        logic [COORD_Y_WIDTH-1:0]     target_y;
        logic [HDR_PAYLOAD_WIDTH-1:0] payload;
    } header_t;

    // First flit of a packet reads as a header, the rest as raw data
    typedef union packed {
        header_t               hdr;
        logic [FLIT_WIDTH-1:0] raw;
    } flit_t;

endpackage

// ==== axis_if.sv ====
interface axis_if;
    import noc_pkg::*;

    logic [FLIT_WIDTH-1:0] tdata;
    logic                  tvalid;
    logic                  tready;
    logic                  tlast; // Last flit of the packet

    modport m (
        output tdata,
        output tvalid,
        output tlast,
        input  tready
    );

    modport s (
        input  tdata,
        input  tvalid,
        input  tlast,
        output tready
    );

endinterface

// ==== flit_fifo.sv ====
module flit_fifo #(
    parameter int FIFO_DEPTH = 4
) (
    input  logic aclk,
    input  logic rst,
    axis_if.s    in,
    axis_if.m    out
);
    import noc_pkg::*;

    localparam int PTR_WIDTH = $clog2(FIFO_DEPTH);
    localparam logic [PTR_WIDTH:0] FULL_COUNT = (PTR_WIDTH + 1)'(FIFO_DEPTH);

    logic [FLIT_WIDTH:0]  mem [FIFO_DEPTH]; // {tlast, tdata}
    logic [PTR_WIDTH-1:0] wr_ptr_q;
    logic [PTR_WIDTH-1:0] rd_ptr_q;
    logic [PTR_WIDTH:0]   count_q;
    logic                 push;
    logic                 pop;

    assign in.tready  = (count_q != FULL_COUNT);
    assign out.tvalid = (count_q != '0);
    assign {out.tlast, out.tdata} = mem[rd_ptr_q]; // Head shows without a read

    assign push = in.tvalid && in.tready;
    assign pop  = out.tvalid && out.tready;

    always_ff @(posedge aclk) begin
        if (rst) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (push) begin
                wr_ptr_q <= wr_ptr_q + PTR_WIDTH'(1); // Wraps, depth is 2**n
            end
            if (pop) begin
                rd_ptr_q <= rd_ptr_q + PTR_WIDTH'(1);
            end
            case ({push, pop})
                2'b10:   count_q <= count_q + (PTR_WIDTH + 1)'(1);
                2'b01:   count_q <= count_q - (PTR_WIDTH + 1)'(1);
                default: count_q <= count_q;
            endcase
        end
    end

    always_ff @(posedge aclk) begin
        if (push) begin
            mem[wr_ptr_q] <= {in.tlast, in.tdata};
        end
    end

endmodule

// ==== header_tracker.sv ====
module header_tracker (
    input  logic                             aclk,
    input  logic                             rst,
    axis_if.s                                in,
    axis_if.m                                out,
    output logic [noc_pkg::COORD_X_WIDTH-1:0] target_x,
    output logic [noc_pkg::COORD_Y_WIDTH-1:0] target_y,
    output logic                             is_header
);
    import noc_pkg::*;

    flit_t                    flit;
    logic                     in_packet_q;
    logic                     xfer;
    logic [COORD_X_WIDTH-1:0] held_x_q;
    logic [COORD_Y_WIDTH-1:0] held_y_q;

    always_comb begin
        flit.raw = in.tdata;
    end

    // Flits pass straight through
    assign out.tdata  = flit.raw;
    assign out.tvalid = in.tvalid;
    assign out.tlast  = in.tlast;
    assign in.tready  = out.tready;

    assign xfer      = in.tvalid && out.tready;
    assign is_header = !in_packet_q;

    // Header view on the first flit, held copy for the body
    assign target_x = is_header ? flit.hdr.target_x : held_x_q;
    assign target_y = is_header ? flit.hdr.target_y : held_y_q;

    // A header with tlast leaves the state cleared
    always_ff @(posedge aclk) begin
        if (rst) begin
            in_packet_q <= 1'b0;
        end else if (xfer) begin
            in_packet_q <= !in.tlast;
        end
    end

    always_ff @(posedge aclk) begin
        if (xfer && is_header) begin
            held_x_q <= flit.hdr.target_x;
            held_y_q <= flit.hdr.target_y;
        end
    end

endmodule

// ==== route_select.sv ====
module route_select #(
    parameter int ROUTER_X = 0,
    parameter int ROUTER_Y = 0
) (
    input logic                             aclk,
    input logic                             rst,
    axis_if.s                               in,
    axis_if.m                               out [noc_pkg::CHANNEL_NUMBER],
    input logic [noc_pkg::COORD_X_WIDTH-1:0] target_x,
    input logic [noc_pkg::COORD_Y_WIDTH-1:0] target_y,
    input logic                             is_header
);
    import noc_pkg::*;

    localparam logic [COORD_X_WIDTH-1:0] POS_X = COORD_X_WIDTH'(ROUTER_X);
    localparam logic [COORD_Y_WIDTH-1:0] POS_Y = COORD_Y_WIDTH'(ROUTER_Y);

    logic [CHANNEL_NUMBER-1:0] ch_ready;
    logic [CHANNEL_NUMBER-1:0] want;
    logic [CHANNEL_NUMBER-1:0] sel;
    logic [CHANNEL_WIDTH-1:0]  choice;
    logic [CHANNEL_WIDTH-1:0]  ctrl;
    logic [CHANNEL_WIDTH-1:0]  lock_ch_q;
    logic                      hit;
    logic                      fwd;

    assign want[CH_LOCAL] = (target_x == POS_X) && (target_y == POS_Y);
    assign want[CH_NORTH] = (target_y < POS_Y);
    assign want[CH_EAST]  = (target_x > POS_X);
    assign want[CH_SOUTH] = (target_y > POS_Y);
    assign want[CH_WEST]  = (target_x < POS_X);

    assign sel = want & ch_ready; // Only ready candidates count
    assign hit = |sel;

    // Local first, then x, y only when x is blocked
    always_comb begin
        choice = CH_LOCAL;
        if (sel[CH_LOCAL]) begin
            choice = CH_LOCAL;
        end else if (sel[CH_EAST]) begin
            choice = CH_EAST;
        end else if (sel[CH_WEST]) begin
            choice = CH_WEST;
        end else if (sel[CH_NORTH]) begin
            choice = CH_NORTH;
        end else if (sel[CH_SOUTH]) begin
            choice = CH_SOUTH;
        end
    end

    assign ctrl      = is_header ? choice : lock_ch_q;
    assign fwd       = !is_header || hit; // Header waits for a ready candidate
    assign in.tready = fwd && ch_ready[ctrl];

    // Route held from header to tlast
    always_ff @(posedge aclk) begin
        if (rst) begin
            lock_ch_q <= CH_LOCAL;
        end else if (in.tvalid && in.tready) begin
            lock_ch_q <= in.tlast ? CH_LOCAL : ctrl;
        end
    end

    for (genvar i = 0; i < CHANNEL_NUMBER; i++) begin : g_ch
        assign ch_ready[i]   = out[i].tready;
        assign out[i].tvalid = in.tvalid && fwd && (ctrl == CHANNEL_WIDTH'(i));
        assign out[i].tdata  = in.tdata;
        assign out[i].tlast  = in.tlast;
    end

endmodule

// ==== port_demux.sv ====
module port_demux (
    input  logic                                                    aclk,
    input  logic                                                    rst,
    axis_if.s                                                       in [noc_pkg::CHANNEL_NUMBER],
    output logic [noc_pkg::CHANNEL_NUMBER-1:0][noc_pkg::FLIT_WIDTH-1:0] out_tdata,
    output logic [noc_pkg::CHANNEL_NUMBER-1:0]                      out_tvalid,
    output logic [noc_pkg::CHANNEL_NUMBER-1:0]                      out_tlast,
    input  logic [noc_pkg::CHANNEL_NUMBER-1:0]                      out_tready
);
    import noc_pkg::*;

    for (genvar i = 0; i < CHANNEL_NUMBER; i++) begin : g_slice
        logic                  valid_q;
        logic                  last_q;
        logic [FLIT_WIDTH-1:0] data_q;
        logic                  load;

        // Takes a new flit while the old one leaves
        assign in[i].tready = !valid_q || out_tready[i];
        assign load         = in[i].tvalid && in[i].tready;

        assign out_tvalid[i] = valid_q;
        assign out_tdata[i]  = data_q;
        assign out_tlast[i]  = last_q;

        always_ff @(posedge aclk) begin
            if (rst) begin
                valid_q <= 1'b0;
            end else if (load) begin
                valid_q <= 1'b1;
            end else if (out_tready[i]) begin
                valid_q <= 1'b0;
            end
        end

        always_ff @(posedge aclk) begin
            if (load) begin
                data_q <= in[i].tdata;
                last_q <= in[i].tlast;
            end
        end
    end

endmodule

// ==== router_input_port.sv ====
module router_input_port #(
    parameter int ROUTER_X   = 0,
    parameter int ROUTER_Y   = 0,
    parameter int FIFO_DEPTH = 4
) (
    input  logic                                                    aclk,
    input  logic                                                    rst,
    input  logic [noc_pkg::FLIT_WIDTH-1:0]                          in_tdata,
    input  logic                                                    in_tvalid,
    input  logic                                                    in_tlast,
    output logic                                                    in_tready,
    output logic [noc_pkg::CHANNEL_NUMBER-1:0][noc_pkg::FLIT_WIDTH-1:0] out_tdata,
    output logic [noc_pkg::CHANNEL_NUMBER-1:0]                      out_tvalid,
    output logic [noc_pkg::CHANNEL_NUMBER-1:0]                      out_tlast,
    input  logic [noc_pkg::CHANNEL_NUMBER-1:0]                      out_tready
);
    import noc_pkg::*;

    logic [COORD_X_WIDTH-1:0] target_x;
    logic [COORD_Y_WIDTH-1:0] target_y;
    logic                     is_header;

    axis_if in_if ();
    axis_if fifo_to_hdr ();
    axis_if hdr_to_rt ();
    axis_if rt_to_dmx [CHANNEL_NUMBER] ();

    assign in_if.tdata  = in_tdata;
    assign in_if.tvalid = in_tvalid;
    assign in_if.tlast  = in_tlast;
    assign in_tready    = in_if.tready;

    flit_fifo #(.FIFO_DEPTH(FIFO_DEPTH)) u_fifo (
        .aclk (aclk),
        .rst  (rst),
        .in   (in_if),
        .out  (fifo_to_hdr)
    );

    header_tracker u_hdr (
        .aclk      (aclk),
        .rst       (rst),
        .in        (fifo_to_hdr),
        .out       (hdr_to_rt),
        .target_x  (target_x),
        .target_y  (target_y),
        .is_header (is_header)
    );

    route_select #(.ROUTER_X(ROUTER_X), .ROUTER_Y(ROUTER_Y)) u_route (
        .aclk      (aclk),
        .rst       (rst),
        .in        (hdr_to_rt),
        .out       (rt_to_dmx),
        .target_x  (target_x),
        .target_y  (target_y),
        .is_header (is_header)
    );

    port_demux u_demux (
        .aclk       (aclk),
        .rst        (rst),
        .in         (rt_to_dmx),
        .out_tdata  (out_tdata),
        .out_tvalid (out_tvalid),
        .out_tlast  (out_tlast),
        .out_tready (out_tready)
    );

endmodule

// ==== tb_router_input_port.sv ====
module tb_router_input_port;
    timeunit 1ns;
    timeprecision 1ps;
    import noc_pkg::*;

    localparam int ROUTER_X   = 1;
    localparam int ROUTER_Y   = 2;
    localparam int FIFO_DEPTH = 4;
    localparam int TIMEOUT    = 200; // Cycles per wait

    logic                                      aclk;
    logic                                      rst;
    logic [FLIT_WIDTH-1:0]                     in_tdata;
    logic                                      in_tvalid;
    logic                                      in_tlast;
    logic                                      in_tready;
    logic [CHANNEL_NUMBER-1:0][FLIT_WIDTH-1:0] out_tdata;
    logic [CHANNEL_NUMBER-1:0]                 out_tvalid;
    logic [CHANNEL_NUMBER-1:0]                 out_tlast;
    logic [CHANNEL_NUMBER-1:0]                 out_tready;

    logic [FLIT_WIDTH:0]       exp_q [CHANNEL_NUMBER][$]; // {tlast, tdata}
    logic [FLIT_WIDTH-1:0]     head_data [CHANNEL_NUMBER];
    logic [CHANNEL_NUMBER-1:0] head_last;
    logic [CHANNEL_NUMBER-1:0] head_avail;
    logic                      rand_ready; // Random out_tready each falling edge

    router_input_port #(
        .ROUTER_X   (ROUTER_X),
        .ROUTER_Y   (ROUTER_Y),
        .FIFO_DEPTH (FIFO_DEPTH)
    ) DUT (.*);

    initial begin
        aclk = 1'b0;
        forever #20 aclk = ~aclk;
    end

    task automatic stop_run(input string line);
        $display("%s", line);
        $display("** FAIL **");
        $fatal(1, "Simulation stopped");
    endtask

    task automatic next_negedge();
        @(negedge aclk);
        if (rand_ready) begin
            out_tready = CHANNEL_NUMBER'($urandom);
        end
    endtask

    // Local, then the x channel, then the y channel, each only when ready
    function automatic int route_of(input int tx, input int ty,
                                    input logic [CHANNEL_NUMBER-1:0] rdy);
        int xc;
        int yc;
        xc = (tx > ROUTER_X) ? int'(CH_EAST) : (tx < ROUTER_X) ? int'(CH_WEST) : -1;
        yc = (ty > ROUTER_Y) ? int'(CH_SOUTH) : (ty < ROUTER_Y) ? int'(CH_NORTH) : -1;
        if (xc < 0 && yc < 0) begin
            return int'(CH_LOCAL);
        end else if (xc >= 0 && (rdy[xc] || yc < 0)) begin
            return xc;
        end else if (yc >= 0 && rdy[yc]) begin
            return yc;
        end
        return (xc >= 0) ? xc : yc; // None ready, header waits on x if there is one
    endfunction

    task automatic send_flit(input logic [FLIT_WIDTH-1:0] data, input logic last);
        int t;
        in_tdata  = data;
        in_tlast  = last;
        in_tvalid = 1'b1;
        for (t = 0; !in_tready; t++) begin
            if (t == TIMEOUT) stop_run("Timeout: in_tready stayed low");
            else next_negedge();
        end
        @(posedge aclk);
        next_negedge();
        in_tvalid = 1'b0;
    endtask

    task automatic send_packet(input int tx, input int ty, input int len,
                               input logic [CHANNEL_NUMBER-1:0] rdy, input logic stall);
        flit_t f;
        int    ch;
        int    n;
        ch = route_of(tx, ty, rdy);
        for (n = 0; n < len; n++) begin
            f.raw = $urandom;
            if (n == 0) begin
                f.hdr.target_x = COORD_X_WIDTH'(tx);
                f.hdr.target_y = COORD_Y_WIDTH'(ty);
            end
            exp_q[ch].push_back({n == len - 1, f.raw});
            send_flit(f.raw, n == len - 1);
            if (n == 0 && stall) begin
                out_tready[ch] = 1'b0; // Header already on its way
            end
        end
    endtask

    task automatic wait_valid(input int ch);
        int t;
        for (t = 0; !out_tvalid[ch]; t++) begin
            if (t == TIMEOUT) stop_run($sformatf("Timeout: channel %0d never went valid", ch));
            else next_negedge();
        end
    endtask

    task automatic wait_empty(input int ch);
        int t;
        for (t = 0; exp_q[ch].size() != 0; t++) begin
            if (t == TIMEOUT) stop_run($sformatf("Timeout: flits missing on channel %0d", ch));
            else next_negedge();
        end
    endtask

    task automatic drain();
        rand_ready = 1'b0;
        out_tready = '1;
        for (int c = 0; c < CHANNEL_NUMBER; c++) begin
            wait_empty(c);
        end
        repeat (3) next_negedge();
    endtask

    // Pop on each output transfer, head is compared at the next edge
    always @(posedge aclk) begin
        logic [FLIT_WIDTH:0] head;
        for (int c = 0; c < CHANNEL_NUMBER; c++) begin
            if (!rst && out_tvalid[c] && out_tready[c] && exp_q[c].size() != 0) begin
                void'(exp_q[c].pop_front());
            end
            head = (exp_q[c].size() != 0) ? exp_q[c][0] : '0;
            head_avail[c] <= (exp_q[c].size() != 0);
            head_last[c]  <= head[FLIT_WIDTH];
            head_data[c]  <= head[FLIT_WIDTH-1:0];
        end
    end

    assert property (@(posedge aclk) $past(rst) |-> (out_tvalid == '0) && in_tready)
        else stop_run($sformatf("Fail at %0d ns: port not idle around reset", $time));

    for (genvar c = 0; c < CHANNEL_NUMBER; c++) begin : g_check
        assert property (@(posedge aclk) disable iff (rst)
            out_tvalid[c] && out_tready[c] |-> head_avail[c]
                && out_tdata[c] == head_data[c] && out_tlast[c] == head_last[c])
            else stop_run($sformatf("Fail at %0d ns: channel %0d sent %h last %b, expected %h",
                                    $time, c, out_tdata[c], out_tlast[c], head_data[c]));
    end

    initial begin
        logic [CHANNEL_NUMBER-1:0] rdy;
        flit_t f;
        int    tx;
        int    ty;
        int    sent;
        int    p;
        void'($urandom(30));
        rst        = 1'b1;
        in_tdata   = '0;
        in_tvalid  = 1'b0;
        in_tlast   = 1'b0;
        out_tready = '1;
        rand_ready = 1'b0;
        repeat (5) @(negedge aclk);
        rst = 1'b0;
        next_negedge();

        for (tx = 0; tx < MAX_ROUTERS_X; tx++) begin // Whole route table
            for (ty = 0; ty < MAX_ROUTERS_Y; ty++) begin
                send_packet(tx, ty, 2, '1, 1'b0);
            end
        end
        drain();

        send_packet(ROUTER_X, ROUTER_Y, 1, '1, 1'b0);
        assert (!out_tvalid[CH_LOCAL])
            else stop_run($sformatf("Fail at %0d ns: local valid one cycle early", $time));
        next_negedge();
        assert (out_tvalid[CH_LOCAL])
            else stop_run($sformatf("Fail at %0d ns: local not valid after two cycles", $time));
        drain();

        // Park a flit on east, the next x and y packet turns north
        out_tready[CH_EAST] = 1'b0;
        send_packet(ROUTER_X + 1, ROUTER_Y, 1, out_tready, 1'b0);
        wait_valid(int'(CH_EAST));
        send_packet(3, 0, 3, out_tready, 1'b0);
        wait_empty(int'(CH_NORTH));
        out_tready[CH_NORTH] = 1'b0;
        send_packet(ROUTER_X, 0, 1, out_tready, 1'b0);
        wait_valid(int'(CH_NORTH));
        rdy = out_tready;
        rdy[CH_NORTH] = 1'b1; // North frees up first
        send_packet(3, 0, 2, rdy, 1'b0);
        repeat (4) next_negedge();
        out_tready[CH_NORTH] = 1'b1;
        wait_empty(int'(CH_NORTH));
        drain();

        send_packet(3, 0, 4, '1, 1'b1); // Body stalls on east, north idle
        repeat (4) next_negedge();
        drain();

        out_tready[CH_EAST] = 1'b0;
        f.raw = $urandom;
        f.hdr.target_x = COORD_X_WIDTH'(ROUTER_X + 1);
        f.hdr.target_y = COORD_Y_WIDTH'(ROUTER_Y);
        for (sent = 0; in_tready && sent < 2 * FIFO_DEPTH; sent++) begin
            exp_q[CH_EAST].push_back({1'b0, f.raw});
            in_tdata  = f.raw;
            in_tlast  = 1'b0;
            in_tvalid = 1'b1;
            @(posedge aclk);
            next_negedge();
            f.raw = $urandom;
        end
        in_tvalid = 1'b0;
        assert (sent == FIFO_DEPTH + 1)
            else stop_run($sformatf("Fail at %0d ns: %0d flits before full", $time, sent));
        repeat (3) next_negedge();
        assert (!in_tready)
            else stop_run($sformatf("Fail at %0d ns: in_tready rose while east blocked", $time));
        out_tready[CH_EAST] = 1'b1;
        exp_q[CH_EAST].push_back({1'b1, f.raw});
        send_flit(f.raw, 1'b1);
        drain();

        rand_ready = 1'b1;
        for (p = 0; p < 40; p++) begin // One candidate per target
            tx = ROUTER_X;
            ty = ROUTER_Y;
            case (int'($urandom % 5))
                1:       tx = 2 + int'($urandom % 2);
                2:       tx = 0;
                3:       ty = int'($urandom % 2);
                4:       ty = 3;
                default: tx = ROUTER_X;
            endcase
            send_packet(tx, ty, 1 + int'($urandom % 4), '1, 1'b0);
        end
        drain();

        $display("** PASS **");
        $finish;
    end

endmodule

// ==== sim.f ====
noc_pkg.sv
axis_if.sv
flit_fifo.sv
header_tracker.sv
route_select.sv
port_demux.sv
router_input_port.sv
tb_router_input_port.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Build with Verilator, run, then look for the pass line in the log
cd "$(dirname "$0")" &&
verilator --binary --assert -f sim.f --top-module tb_router_input_port &&
./obj_dir/Vtb_router_input_port | tee sim.log &&
grep -qF '** PASS **' sim.log ||
exit 1
